// ==== verilog/udp_pkg.sv ====
`default_nettype none

package udp_pkg;

	// Burst shape
	localparam int NBURST = 3;                      // Extra datagrams after the first
	localparam int BURST_W = $clog2(NBURST + 1);
	localparam logic [15:0] UDP_HDR_BYTES = 16'd8;  // Added to payload for length

	// Arbiter sizing
	localparam int N_CLIENTS = 2;
	localparam int CLIENT_W = (N_CLIENTS > 1) ? $clog2(N_CLIENTS) : 1;

	// Static responder ports
	localparam logic [15:0] PORT_STATIC_A = 16'hd001;
	localparam logic [15:0] PORT_STATIC_B = 16'hd002;

	typedef struct packed {
		logic [15:0] srcport;
		logic [15:0] dstport;
		logic [15:0] length;
		logic [15:0] checksum;
	} udp_hdr_t;

	// Receive side, hdr only valid with newhead
	typedef struct packed {
		logic        newhead;
		udp_hdr_t    hdr;
		logic [7:0]  data;
		logic        dven;
		logic        error;
	} udp_rx_t;

	// Transmit side, hdr held for the whole datagram
	typedef struct packed {
		udp_hdr_t    hdr;
		logic [7:0]  data;
		logic        dven;
		logic        error;
	} udp_tx_t;

endpackage

`default_nettype wire

// ==== verilog/udp_static_responder.sv ====
`timescale 1ns/1ps
`default_nettype none

module udp_static_responder #(
	parameter logic [15:0] PORT = udp_pkg::PORT_STATIC_A
) (
	input  logic             clk,
	input  logic             reset,
	input  udp_pkg::udp_rx_t rx,
	input  logic [15:0]      nbyte,
	input  logic             ack,
	output logic             request,
	output udp_pkg::udp_tx_t tx
);

	import udp_pkg::*;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_DATA,
		RX_TAIL
	} rx_state_t;

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_TAIL
	} tx_state_t;

	rx_state_t rx_state;
	tx_state_t tx_state;

	logic               burst_busy;   // From match until the last tail
	logic [BURST_W-1:0] burst_cnt;    // Datagrams still owed after this one
	logic [15:0]        byte_cnt;
	logic [7:0]         data_q;
	logic               dven_q;
	logic [15:0]        peer_port;    // Sender's source port
	logic               match;
	logic               last_byte;

	// Headers are only taken when nothing is in flight
	assign match = rx.newhead && (rx.hdr.dstport == PORT) &&
		(rx_state == RX_IDLE) && !burst_busy;

	assign last_byte = (byte_cnt == nbyte);

	// Receive side follows the datagram, payload itself is dropped
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rx_state <= RX_IDLE;
		end else begin
			case (rx_state)
				RX_IDLE: begin
					if (match)
						rx_state <= RX_DATA;
				end
				RX_DATA: begin
					if (!rx.dven)
						rx_state <= RX_TAIL;   // dven fell, datagram over
				end
				RX_TAIL: begin
					rx_state <= RX_IDLE;
				end
				default: begin
					rx_state <= RX_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (match)
			peer_port <= rx.hdr.srcport;
	end

	// Burst bookkeeping and request pulses
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			burst_busy <= 1'b0;
			burst_cnt  <= '0;
			request    <= 1'b0;
		end else begin
			request <= 1'b0;
			if (match) begin
				burst_busy <= 1'b1;
				burst_cnt  <= BURST_W'(NBURST);
				request    <= 1'b1;     // First request right after newhead
			end else if (tx_state == TX_TAIL) begin
				if (burst_cnt != '0) begin
					burst_cnt <= burst_cnt - 1'b1;
					request   <= 1'b1;
				end else begin
					burst_busy <= 1'b0;
				end
			end
		end
	end

	// Transmit FSM, one datagram per ack
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			tx_state <= TX_IDLE;
			dven_q   <= 1'b0;
			byte_cnt <= '0;
		end else begin
			case (tx_state)
				TX_IDLE: begin
					if (ack)
						tx_state <= TX_START;
				end
				TX_START: begin
					tx_state <= TX_DATA;
					dven_q   <= 1'b1;
					byte_cnt <= 16'd1;
				end
				TX_DATA: begin
					if (last_byte) begin
						tx_state <= TX_TAIL;
						dven_q   <= 1'b0;
					end else begin
						byte_cnt <= byte_cnt + 16'd1;
					end
				end
				TX_TAIL: begin
					tx_state <= TX_IDLE;
					byte_cnt <= '0;
				end
				default: begin
					tx_state <= TX_IDLE;
					dven_q   <= 1'b0;
				end
			endcase
		end
	end

	// Counting pattern, wraps at 256
	always_ff @(posedge clk) begin
		if (tx_state == TX_DATA && !last_byte)
			data_q <= byte_cnt[7:0];
		else
			data_q <= 8'd0;
	end

	always_comb begin
		tx.hdr.srcport  = PORT;         // Ports swapped for the reply
		tx.hdr.dstport  = peer_port;
		tx.hdr.length   = nbyte + UDP_HDR_BYTES;
		tx.hdr.checksum = 16'd0;
		tx.data         = data_q;
		tx.dven         = dven_q;
		tx.error        = 1'b0;
	end

	a_no_dven_idle: assert property (@(posedge clk) disable iff (reset)
		(tx_state == TX_IDLE) |-> !tx.dven);

	// Arbiter must never grant a request in its own cycle
	a_req_not_with_ack: assert property (@(posedge clk) disable iff (reset)
		!(request && ack));

endmodule

`default_nettype wire

// ==== verilog/udp_tx_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module udp_tx_arbiter (
	input  logic                          clk,
	input  logic                          reset,
	input  logic [udp_pkg::N_CLIENTS-1:0] request,
	input  udp_pkg::udp_tx_t              client_tx [udp_pkg::N_CLIENTS],
	output logic [udp_pkg::N_CLIENTS-1:0] ack,
	output udp_pkg::udp_tx_t              tx
);

	import udp_pkg::*;

	logic [N_CLIENTS-1:0] pending;
	logic [CLIENT_W-1:0]  rr_ptr;      // Client with first claim on the next grant
	logic [CLIENT_W-1:0]  owner;       // Client currently on the link
	logic [CLIENT_W-1:0]  next_idx;
	logic                 next_valid;
	logic                 busy_q;
	logic                 seen_dven;   // Owner has started its payload
	logic                 owner_dven;

	// Search pending flags starting at rr_ptr
	always_comb begin : pick
		int idx;
		next_idx   = rr_ptr;
		next_valid = 1'b0;
		for (int k = N_CLIENTS - 1; k >= 0; k--) begin
			idx = (int'(rr_ptr) + k) % N_CLIENTS;
			if (pending[idx]) begin
				next_idx   = CLIENT_W'(idx);   // Closest to rr_ptr wins
				next_valid = 1'b1;
			end
		end
	end

	always_comb begin
		ack = '0;
		if (next_valid && !busy_q)
			ack[next_idx] = 1'b1;
	end

	assign owner_dven = client_tx[owner].dven;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pending   <= '0;
			rr_ptr    <= '0;
			owner     <= '0;
			busy_q    <= 1'b0;
			seen_dven <= 1'b0;
		end else begin
			pending <= (pending | request) & ~ack;
			if (|ack) begin
				busy_q    <= 1'b1;
				seen_dven <= 1'b0;
				owner     <= next_idx;
				if (next_idx == CLIENT_W'(N_CLIENTS - 1))
					rr_ptr <= '0;
				else
					rr_ptr <= next_idx + 1'b1;
			end else if (busy_q) begin
				if (owner_dven) begin
					seen_dven <= 1'b1;
				end else if (seen_dven) begin
					busy_q    <= 1'b0;   // Tail cycle, link free next cycle
					seen_dven <= 1'b0;
				end
			end
		end
	end

	// Link mux, quiet while idle
	always_comb begin
		tx = '0;
		if (busy_q)
			tx = client_tx[owner];
	end

	a_ack_onehot: assert property (@(posedge clk) disable iff (reset)
		$onehot0(ack));

	// Previous owner has finished its payload before the next grant
	a_ack_when_idle: assert property (@(posedge clk) disable iff (reset)
		(|ack) |-> !owner_dven);

endmodule

`default_nettype wire

// ==== verilog/udp_service_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module udp_service_top (
	input  logic             clk,
	input  logic             reset,
	input  udp_pkg::udp_rx_t rx,
	input  logic [15:0]      nbyte,
	output udp_pkg::udp_tx_t tx
);

	import udp_pkg::*;

	logic [N_CLIENTS-1:0] request;
	logic [N_CLIENTS-1:0] ack;
	udp_tx_t              client_tx [N_CLIENTS];

	// Responder on the first static port
	udp_static_responder #(
		.PORT (PORT_STATIC_A)
	) u_static_a (
		.clk     (clk),
		.reset   (reset),
		.rx      (rx),
		.nbyte   (nbyte),
		.ack     (ack[0]),
		.request (request[0]),
		.tx      (client_tx[0])
	);

	// Responder on the second static port
	udp_static_responder #(
		.PORT (PORT_STATIC_B)
	) u_static_b (
		.clk     (clk),
		.reset   (reset),
		.rx      (rx),
		.nbyte   (nbyte),
		.ack     (ack[1]),
		.request (request[1]),
		.tx      (client_tx[1])
	);

	// Shares the single transmit link
	udp_tx_arbiter u_tx_arbiter (
		.clk       (clk),
		.reset     (reset),
		.request   (request),
		.client_tx (client_tx),
		.ack       (ack),
		.tx        (tx)
	);

endmodule

`default_nettype wire

// ==== sim/tb_udp_vectors.svh ====
`ifndef TB_UDP_VECTORS_SVH
`define TB_UDP_VECTORS_SVH

// Columns: dstport, srcport, nbyte, second header follows, dstport2, srcport2,
// expected datagrams from port d001, expected datagrams from port d002
typedef struct packed {
	logic [15:0] dstport;
	logic [15:0] srcport;
	logic [15:0] nbyte;
	logic        second;
	logic [15:0] dstport2;
	logic [15:0] srcport2;
	logic [3:0]  exp_a;
	logic [3:0]  exp_b;
} vec_row_t;

localparam int N_VECTORS = 8;

vec_row_t vec_table [N_VECTORS];

task automatic load_vectors;
	// Single request to each responder
	vec_table[0] = '{16'hd001, 16'h1234, 16'd5, 1'b0, 16'h0000, 16'h0000, 4'd4, 4'd0};
	vec_table[1] = '{16'hd002, 16'h4321, 16'd3, 1'b0, 16'h0000, 16'h0000, 4'd0, 4'd4};
	// Nobody listens here
	vec_table[2] = '{16'hd005, 16'h1111, 16'd4, 1'b0, 16'h0000, 16'h0000, 4'd0, 4'd0};
	// Both responders busy at once
	vec_table[3] = '{16'hd001, 16'h2222, 16'd2, 1'b1, 16'hd002, 16'h3333, 4'd4, 4'd4};
	// Repeat to a busy port is dropped
	vec_table[4] = '{16'hd001, 16'h5555, 16'd6, 1'b1, 16'hd001, 16'h6666, 4'd4, 4'd0};
	vec_table[5] = '{16'hd002, 16'h7777, 16'd1, 1'b1, 16'hd001, 16'h8888, 4'd4, 4'd4};
	// Long payload, counting bytes wrap past 255
	vec_table[6] = '{16'hd002, 16'h9999, 16'd260, 1'b0, 16'h0000, 16'h0000, 4'd0, 4'd4};
	vec_table[7] = '{16'hd000, 16'haaaa, 16'd3, 1'b1, 16'hd003, 16'hbbbb, 4'd0, 4'd0};
endtask

`endif

// ==== sim/tb_udp_service.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_udp_service;

	import udp_pkg::*;

	`include "tb_udp_vectors.svh"

	localparam int QUIET_CYCLES = 40;   // Link idle this long ends a row

	logic        clk;
	logic        reset;
	udp_rx_t     rx;
	logic [15:0] nbyte;
	udp_tx_t     tx;

	// Monitor state
	udp_hdr_t    got_hdr [$];   // One entry per finished datagram
	udp_hdr_t    cur_hdr;
	logic        in_pkt;
	int          byte_idx;
	int          dven_cycles;
	logic [15:0] cur_nbyte;     // Payload length the current row expects

	int cycle_cnt = 0;
	int timeout_limit = 0;

	udp_service_top u_udp_service_top (
		.clk   (clk),
		.reset (reset),
		.rx    (rx),
		.nbyte (nbyte),
		.tx    (tx)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic check_value(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		if (actual !== expected) begin
			$display("FAILED time=%0t signal=%s actual=%0h expected=%0h",
				$time, name, actual, expected);
			$display("Result: FAILED");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	// Header strobe, then a short payload that the DUT drops
	task automatic send_datagram(input logic [15:0] dst, input logic [15:0] src);
		int unsigned plen;
		plen = 1 + ($urandom % 6);
		@(posedge clk);
		rx.newhead          <= 1'b1;
		rx.hdr.srcport      <= src;
		rx.hdr.dstport      <= dst;
		rx.hdr.length       <= 16'(plen + 8);
		rx.hdr.checksum     <= 16'd0;
		rx.dven             <= 1'b0;
		for (int i = 0; i < int'(plen); i++) begin
			@(posedge clk);
			rx.newhead <= 1'b0;
			rx.dven    <= 1'b1;
			rx.data    <= 8'(i);
		end
		@(posedge clk);
		rx.dven <= 1'b0;
		rx.data <= 8'd0;
		rx.hdr  <= '0;
	endtask

	task automatic wait_link_quiet;
		int quiet;
		quiet = 0;
		while (quiet < QUIET_CYCLES) begin
			@(negedge clk);
			if (tx.dven)
				quiet = 0;
			else
				quiet++;
		end
	endtask

	// Compare the datagrams of one row with what its headers call for
	task automatic verify_row(input vec_row_t row, input int start_idx);
		logic [15:0] peer_a;
		logic [15:0] peer_b;
		int          cnt_a;
		int          cnt_b;
		udp_hdr_t    h;
		peer_a = 16'd0;
		peer_b = 16'd0;
		cnt_a  = 0;
		cnt_b  = 0;
		// First header to a port wins, a repeat during the burst is ignored
		if (row.dstport == 16'hd001)
			peer_a = row.srcport;
		else if (row.second && row.dstport2 == 16'hd001)
			peer_a = row.srcport2;
		if (row.dstport == 16'hd002)
			peer_b = row.srcport;
		else if (row.second && row.dstport2 == 16'hd002)
			peer_b = row.srcport2;

		check_value("monitor in datagram", 64'(in_pkt), 64'(0));
		for (int k = start_idx; k < got_hdr.size(); k++) begin
			h = got_hdr[k];
			if (h.srcport == 16'hd002) begin
				cnt_b++;
				check_value("tx.hdr.dstport", 64'(h.dstport), 64'(peer_b));
			end else begin
				cnt_a++;
				check_value("tx.hdr.srcport", 64'(h.srcport), 64'(16'hd001));
				check_value("tx.hdr.dstport", 64'(h.dstport), 64'(peer_a));
			end
			check_value("tx.hdr.length", 64'(h.length), 64'(row.nbyte + 16'd8));
			check_value("tx.hdr.checksum", 64'(h.checksum), 64'(0));
		end
		check_value("datagrams from d001", 64'(cnt_a), 64'(row.exp_a));
		check_value("datagrams from d002", 64'(cnt_b), 64'(row.exp_b));
	endtask

	// Collects tx datagrams and checks bytes as they pass
	always @(negedge clk) begin
		if (reset) begin
			in_pkt      = 1'b0;
			byte_idx    = 0;
			dven_cycles = 0;
		end else begin
			check_value("tx.error", 64'(tx.error), 64'(0));
			if (tx.dven) begin
				dven_cycles++;
				if (!in_pkt) begin
					in_pkt   = 1'b1;
					cur_hdr  = tx.hdr;
					byte_idx = 0;
				end
				check_value("tx.hdr", 64'(tx.hdr), 64'(cur_hdr));   // No interleave
				check_value("tx.data", 64'(tx.data), 64'(byte_idx[7:0]));
				byte_idx++;
			end else if (in_pkt) begin
				in_pkt = 1'b0;
				check_value("tx.hdr in tail", 64'(tx.hdr), 64'(cur_hdr));
				check_value("payload bytes", 64'(byte_idx), 64'(cur_nbyte));
				got_hdr.push_back(cur_hdr);
			end
		end
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (timeout_limit > 0 && cycle_cnt >= timeout_limit) begin
			$display("Simulation timed out after %0d cycles", cycle_cnt);
			$display("Result: FAILED");
			$fatal(1, "Timeout");
		end
	end

	initial begin
		int unsigned gap;
		int          max_nbyte;
		int          start_idx;
		vec_row_t    row;

		void'($urandom(94390));
		reset     = 1'b1;
		rx        = '0;
		nbyte     = 16'd1;
		cur_nbyte = 16'd1;
		load_vectors();

		max_nbyte = 0;
		for (int r = 0; r < N_VECTORS; r++) begin
			if (int'(vec_table[r].nbyte) > max_nbyte)
				max_nbyte = int'(vec_table[r].nbyte);
		end
		timeout_limit = N_VECTORS * (NBURST + 1) * (max_nbyte + 4) * 2 +
			N_VECTORS * (QUIET_CYCLES + 40) + 200;

		repeat (5) @(posedge clk);
		reset <= 1'b0;

		// Link must stay silent before any header
		repeat (20) @(posedge clk);
		check_value("tx.dven cycles before first header", 64'(dven_cycles), 64'(0));

		for (int r = 0; r < N_VECTORS; r++) begin
			row = vec_table[r];
			gap = $urandom % 8;
			repeat (gap) @(posedge clk);
			@(posedge clk);
			nbyte     <= row.nbyte;   // Held for the whole burst
			cur_nbyte = row.nbyte;
			start_idx = got_hdr.size();
			send_datagram(row.dstport, row.srcport);
			if (row.second) begin
				@(posedge clk);   // Receive side of the first is idle again
				send_datagram(row.dstport2, row.srcport2);
			end
			wait_link_quiet();
			verify_row(row, start_idx);
		end

		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+sim
verilog/udp_pkg.sv
verilog/udp_static_responder.sv
verilog/udp_tx_arbiter.sv
verilog/udp_service_top.sv
sim/tb_udp_service.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the UDP service testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -f compile.f \
	--top-module tb_udp_service -Mdir obj_dir -o tb_udp_service > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_udp_service > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"

if grep -q "Result: FAILED" "$SIM_LOG"; then
	echo "Simulation reported a failure"
	exit 1
fi

if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

exit 0
